// File: rtl/riscv_pkg.sv
// RISC-V integer subset
// Major opcodes, funct codes and the internal ALU and branch operations
`default_nettype none

package riscv_pkg;

    localparam int INSTR_WIDTH = 32;

    // ADDI x0, x0, 0
    localparam logic [INSTR_WIDTH-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    // funct3 encodings
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 encodings
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Operation carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_PASS_B, ALU_NOP
    } alu_op_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_t;

endpackage

`default_nettype wire

// File: rtl/drac_pkg.sv
// Pipeline definitions
// Datapath widths, stage register layouts, redirect select and reset entries
`default_nettype none

package drac_pkg;
    import riscv_pkg::*;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       bus64_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        logic                   valid;
        addr_t                  pc;
        logic [INSTR_WIDTH-1:0] instr;
    } if_id_stage_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_we;
        bus64_t    imm;
        logic      use_imm;   // operand B taken from imm
        alu_op_t   alu_op;
        branch_t   branch;
    } id_rr_stage_t;

    typedef struct packed {
        id_rr_stage_t instr;
        bus64_t       rs1_data;
        bus64_t       rs2_data;
    } rr_exe_stage_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        reg_addr_t rd;
        logic      reg_we;
        bus64_t    result;
    } exe_wb_stage_t;

    // Source of the next fetch address
    typedef enum logic [1:0] {SEL_SEQ, SEL_JUMP_DECODE, SEL_JUMP_EXECUTION} sel_addr_t;

    // Empty entries loaded into the stage registers at reset
    localparam if_id_stage_t IF_ID_RESET = '{valid: 1'b0, pc: '0, instr: NOP_INSTR};
    localparam id_rr_stage_t ID_RR_RESET = '{
        valid: 1'b0, pc: '0, rs1: '0, rs2: '0, rd: '0, reg_we: 1'b0,
        imm: '0, use_imm: 1'b0, alu_op: ALU_NOP, branch: BR_NONE
    };
    localparam rr_exe_stage_t RR_EXE_RESET = '{instr: ID_RR_RESET, rs1_data: '0, rs2_data: '0};
    localparam exe_wb_stage_t EXE_WB_RESET = '{
        valid: 1'b0, pc: '0, rd: '0, reg_we: 1'b0, result: '0
    };

endpackage

`default_nettype wire

// File: rtl/stage_ctrl_if.sv
// Pipeline control bundle
// Stall, flushes and the fetch redirect, driven by the control unit
`timescale 1ns/1ps
`default_nettype none

interface stage_ctrl_if;
    import drac_pkg::*;

    logic      stall_if;
    logic      flush_if;
    logic      flush_id;
    logic      flush_rr;
    sel_addr_t sel_addr;
    addr_t     redirect_pc;

    modport ctrl (output stall_if, flush_if, flush_id, flush_rr, sel_addr, redirect_pc);

    modport fetch (input stall_if, flush_if, sel_addr, redirect_pc);

    modport pipe (input flush_id, flush_rr);

endinterface

`default_nettype wire

// File: rtl/if_stage.sv
// Fetch stage
// Keeps the PC, issues one instruction request per cycle and registers
// the response, or a bubble, into the fetch-to-decode register
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire drac_pkg::addr_t                   reset_addr_i,
    stage_ctrl_if.fetch                            ctrl,
    input  wire logic                              icache_resp_valid_i,
    input  wire logic [riscv_pkg::INSTR_WIDTH-1:0] icache_resp_instr_i,
    output logic                                   icache_req_valid_o,
    output drac_pkg::addr_t                        icache_req_addr_o,
    output drac_pkg::if_id_stage_t                 fetch_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    addr_t pc_q;        // address whose response is due now
    addr_t pc_d;
    logic  req_en_q;
    logic  inflight_q;  // response due now belongs to a live request
    logic  fetch_hit;

    assign fetch_hit = icache_resp_valid_i && inflight_q;

    // Next request: redirect, retry on a miss, or the next word
    always_comb begin
        if (ctrl.sel_addr != SEL_SEQ) begin
            pc_d = ctrl.redirect_pc;
        end else if (ctrl.stall_if || !inflight_q) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + 64'd4;
        end
    end

    assign icache_req_valid_o = req_en_q;
    assign icache_req_addr_o  = pc_d;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q       <= reset_addr_i;
            req_en_q   <= 1'b0;
            inflight_q <= 1'b0;
            fetch_o    <= IF_ID_RESET;
        end else begin
            pc_q          <= pc_d;
            req_en_q      <= 1'b1;
            inflight_q    <= req_en_q;
            // Misses and flushed slots go down as bubbles
            fetch_o.valid <= fetch_hit && !ctrl.flush_if;
            fetch_o.pc    <= pc_q;
            fetch_o.instr <= fetch_hit ? icache_resp_instr_i : NOP_INSTR;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decoder.sv
// Decode stage
// Maps the subset to internal operations, builds immediates, resolves JAL
// targets and fills the decode-to-read register
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,
    stage_ctrl_if.pipe                  ctrl,
    input  wire drac_pkg::if_id_stage_t decode_i,
    output drac_pkg::id_rr_stage_t      decode_o,
    output logic                        jump_valid_o,
    output drac_pkg::addr_t             jump_addr_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    logic [INSTR_WIDTH-1:0] instr;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    bus64_t                 imm_i;
    bus64_t                 imm_u;
    bus64_t                 imm_b;
    bus64_t                 imm_j;
    id_rr_stage_t           id_d;

    assign instr  = decode_i.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_b = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Anything not matched below stays a no-op
        id_d       = ID_RR_RESET;
        id_d.valid = decode_i.valid;
        id_d.pc    = decode_i.pc;
        id_d.rs1   = instr[19:15];
        id_d.rs2   = instr[24:20];
        id_d.rd    = instr[11:7];
        case (instr[6:0])
            OP: begin
                id_d.reg_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: id_d.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  id_d.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     id_d.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      id_d.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     id_d.alu_op = ALU_XOR;
                    default:               id_d.reg_we = 1'b0;
                endcase
            end
            OP_IMM: begin
                if (funct3 == F3_ADD_SUB) begin
                    id_d.reg_we  = 1'b1;
                    id_d.use_imm = 1'b1;
                    id_d.imm     = imm_i;
                    id_d.alu_op  = ALU_ADD;
                end
            end
            LUI: begin
                id_d.reg_we  = 1'b1;
                id_d.use_imm = 1'b1;
                id_d.imm     = imm_u;
                id_d.alu_op  = ALU_PASS_B;
            end
            BRANCH: begin
                id_d.imm = imm_b;
                case (funct3)
                    F3_BEQ:  id_d.branch = BR_EQ;
                    F3_BNE:  id_d.branch = BR_NE;
                    default: id_d.branch = BR_NONE;
                endcase
            end
            JAL: begin
                // Link value travels as the immediate
                id_d.reg_we  = 1'b1;
                id_d.use_imm = 1'b1;
                id_d.imm     = decode_i.pc + 64'd4;
                id_d.alu_op  = ALU_PASS_B;
            end
            default: ;
        endcase
    end

    assign jump_valid_o = decode_i.valid && (instr[6:0] == JAL);
    assign jump_addr_o  = decode_i.pc + imm_j;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            decode_o <= ID_RR_RESET;
        end else begin
            decode_o       <= id_d;
            decode_o.valid <= id_d.valid && !ctrl.flush_id;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rr_stage.sv
// Register read stage
// 32 x 64-bit register file, written from write-back before it is read,
// and the read-to-execute register
`timescale 1ns/1ps
`default_nettype none

module rr_stage (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    stage_ctrl_if.pipe                   ctrl,
    input  wire drac_pkg::id_rr_stage_t  rr_i,
    input  wire drac_pkg::exe_wb_stage_t wb_i,
    output drac_pkg::rr_exe_stage_t      rr_o
);
    import drac_pkg::*;

    bus64_t regs_q [2**REG_ADDR_W];
    logic   wb_write;
    bus64_t rs1_data;
    bus64_t rs2_data;

    // x0 is never written
    assign wb_write = wb_i.valid && wb_i.reg_we && (wb_i.rd != '0);

    always_ff @(posedge clk_i) begin
        if (wb_write) begin
            regs_q[wb_i.rd] <= wb_i.result;
        end
    end

    // Same-cycle write shows through to the read ports
    assign rs1_data = (rr_i.rs1 == '0) ? '0 :
                      (wb_write && wb_i.rd == rr_i.rs1) ? wb_i.result : regs_q[rr_i.rs1];
    assign rs2_data = (rr_i.rs2 == '0) ? '0 :
                      (wb_write && wb_i.rd == rr_i.rs2) ? wb_i.result : regs_q[rr_i.rs2];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rr_o <= RR_EXE_RESET;
        end else begin
            rr_o.instr       <= rr_i;
            rr_o.instr.valid <= rr_i.valid && !ctrl.flush_rr;
            rr_o.rs1_data    <= rs1_data;
            rr_o.rs2_data    <= rs2_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/exe_stage.sv
// Execute stage
// Write-back bypass, ALU, BEQ/BNE resolution and the execute-to-write-back
// register
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire drac_pkg::rr_exe_stage_t exe_i,
    input  wire drac_pkg::exe_wb_stage_t wb_i,
    output logic                         branch_taken_o,
    output drac_pkg::addr_t              branch_target_o,
    output drac_pkg::exe_wb_stage_t      wb_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    id_rr_stage_t instr;
    logic         wb_fwd_ok;
    logic         fwd_rs1;
    logic         fwd_rs2;
    bus64_t       op_a;
    bus64_t       rs2_val;
    bus64_t       op_b;
    bus64_t       result;
    logic         operands_equal;

    assign instr = exe_i.instr;

    // Bypass from the instruction one slot ahead
    assign wb_fwd_ok = wb_i.valid && wb_i.reg_we && (wb_i.rd != '0);
    assign fwd_rs1   = wb_fwd_ok && (wb_i.rd == instr.rs1);
    assign fwd_rs2   = wb_fwd_ok && (wb_i.rd == instr.rs2);

    assign op_a    = fwd_rs1 ? wb_i.result : exe_i.rs1_data;
    assign rs2_val = fwd_rs2 ? wb_i.result : exe_i.rs2_data;
    assign op_b    = instr.use_imm ? instr.imm : rs2_val;

    always_comb begin
        case (instr.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // Branches compare rs1 against rs2, never against the immediate
    assign operands_equal  = (op_a == rs2_val);
    assign branch_taken_o  = instr.valid &&
                             ((instr.branch == BR_EQ && operands_equal) ||
                              (instr.branch == BR_NE && !operands_equal));
    assign branch_target_o = instr.pc + instr.imm;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wb_o <= EXE_WB_RESET;
        end else begin
            wb_o.valid  <= instr.valid;
            wb_o.pc     <= instr.pc;
            wb_o.rd     <= instr.rd;
            wb_o.reg_we <= instr.reg_we;
            wb_o.result <= result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
// Pipeline control unit
// Picks one fetch redirect from the decode jump and the execute branch,
// raises the matching flushes and stalls fetch on a missing response
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    stage_ctrl_if.ctrl           ctrl,
    input  wire logic            icache_resp_valid_i,
    input  wire logic            jump_valid_i,
    input  wire drac_pkg::addr_t jump_addr_i,
    input  wire logic            branch_taken_i,
    input  wire drac_pkg::addr_t branch_target_i
);
    import drac_pkg::*;

    always_comb begin
        ctrl.stall_if    = !icache_resp_valid_i;
        ctrl.flush_if    = 1'b0;
        ctrl.flush_id    = 1'b0;
        ctrl.flush_rr    = 1'b0;
        ctrl.sel_addr    = SEL_SEQ;
        ctrl.redirect_pc = jump_addr_i;

        // Execute wins: a jump in decode may be on the wrong path
        if (branch_taken_i) begin
            ctrl.sel_addr    = SEL_JUMP_EXECUTION;
            ctrl.redirect_pc = branch_target_i;
            ctrl.flush_if    = 1'b1;
            ctrl.flush_id    = 1'b1;
            ctrl.flush_rr    = 1'b1;
        end else if (jump_valid_i) begin
            // Only the slot fetched behind the JAL is lost
            ctrl.sel_addr = SEL_JUMP_DECODE;
            ctrl.flush_if = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
// Integer pipeline datapath
// Five in-order stages (fetch, decode, register read, execute, write-back)
// with a plain-strobe fetch port and a commit port for retired results
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire drac_pkg::addr_t                   reset_addr_i,
    // Instruction fetch
    input  wire logic                              icache_resp_valid_i,
    input  wire logic [riscv_pkg::INSTR_WIDTH-1:0] icache_resp_instr_i,
    output logic                                   icache_req_valid_o,
    output drac_pkg::addr_t                        icache_req_addr_o,
    // Commit
    output logic                                   commit_valid_o,
    output drac_pkg::addr_t                        commit_pc_o,
    output logic                                   commit_we_o,
    output drac_pkg::reg_addr_t                    commit_rd_o,
    output drac_pkg::bus64_t                       commit_data_o
);
    import drac_pkg::*;

    stage_ctrl_if ctrl_if ();

    if_id_stage_t  stage_if_id;
    id_rr_stage_t  stage_id_rr;
    rr_exe_stage_t stage_rr_exe;
    exe_wb_stage_t stage_exe_wb;

    // Redirect requests
    logic  jump_valid;
    addr_t jump_addr;
    logic  branch_taken;
    addr_t branch_target;

    control_unit control_unit_inst (
        .ctrl                (ctrl_if.ctrl),
        .icache_resp_valid_i (icache_resp_valid_i),
        .jump_valid_i        (jump_valid),
        .jump_addr_i         (jump_addr),
        .branch_taken_i      (branch_taken),
        .branch_target_i     (branch_target)
    );

    if_stage if_stage_inst (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .ctrl                (ctrl_if.fetch),
        .icache_resp_valid_i (icache_resp_valid_i),
        .icache_resp_instr_i (icache_resp_instr_i),
        .icache_req_valid_o  (icache_req_valid_o),
        .icache_req_addr_o   (icache_req_addr_o),
        .fetch_o             (stage_if_id)
    );

    decoder decoder_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ctrl         (ctrl_if.pipe),
        .decode_i     (stage_if_id),
        .decode_o     (stage_id_rr),
        .jump_valid_o (jump_valid),
        .jump_addr_o  (jump_addr)
    );

    rr_stage rr_stage_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .ctrl   (ctrl_if.pipe),
        .rr_i   (stage_id_rr),
        .wb_i   (stage_exe_wb),
        .rr_o   (stage_rr_exe)
    );

    exe_stage exe_stage_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .exe_i           (stage_rr_exe),
        .wb_i            (stage_exe_wb),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .wb_o            (stage_exe_wb)
    );

    // Every valid write-back retires in its cycle
    assign commit_valid_o = stage_exe_wb.valid;
    assign commit_pc_o    = stage_exe_wb.pc;
    assign commit_we_o    = stage_exe_wb.valid && stage_exe_wb.reg_we &&
                            (stage_exe_wb.rd != '0);
    assign commit_rd_o    = stage_exe_wb.rd;
    assign commit_data_o  = stage_exe_wb.result;

endmodule

`default_nettype wire

// File: sim/tb_datapath.sv
// Testbench for the integer pipeline datapath
// Acts as instruction memory, runs a golden ISA model of the same program
// and checks every retired instruction on the commit port
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;
    import drac_pkg::*;
    import riscv_pkg::*;

    localparam addr_t RESET_ADDR = 64'h0000_0000_0000_1000;
    localparam int    PROG_LEN   = 37;

    logic                   clk_i;
    logic                   rstn_i;
    addr_t                  reset_addr_i;
    logic                   icache_resp_valid_i;
    logic [INSTR_WIDTH-1:0] icache_resp_instr_i;
    logic                   icache_req_valid_o;
    addr_t                  icache_req_addr_o;
    logic                   commit_valid_o;
    addr_t                  commit_pc_o;
    logic                   commit_we_o;
    reg_addr_t              commit_rd_o;
    bus64_t                 commit_data_o;

    logic [31:0] prog [PROG_LEN];
    bus64_t      gold_regs [32];
    addr_t       exp_pc [$];
    logic        exp_we [$];
    reg_addr_t   exp_rd [$];
    bus64_t      exp_data [$];

    logic        withhold_en;
    logic        pend_valid;
    addr_t       pend_addr;
    int          errors;
    int          timeouts;
    int          checked;

    datapath datapath_inst (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .icache_resp_valid_i (icache_resp_valid_i),
        .icache_resp_instr_i (icache_resp_instr_i),
        .icache_req_valid_o  (icache_req_valid_o),
        .icache_req_addr_o   (icache_req_addr_o),
        .commit_valid_o      (commit_valid_o),
        .commit_pc_o         (commit_pc_o),
        .commit_we_o         (commit_we_o),
        .commit_rd_o         (commit_rd_o),
        .commit_data_o       (commit_data_o)
    );

    always #50 clk_i = ~clk_i;

    // Instruction encoders
    function automatic logic [31:0] reg_op_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input logic [19:0] upper);
        return {upper, rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Memory contents, NOP outside the program
    function automatic logic [31:0] word_at(input addr_t a);
        if (a >= RESET_ADDR && a < RESET_ADDR + 4 * PROG_LEN) begin
            return prog[(a - RESET_ADDR) >> 2];
        end
        return NOP_INSTR;
    endfunction

    task automatic load_program();
        prog[0]  = addi_word(1, 0, 5);
        prog[1]  = addi_word(2, 0, 7);
        prog[2]  = reg_op_word(7'h00, 3'b000, 3, 1, 2);   // distance one and two
        prog[3]  = reg_op_word(7'h20, 3'b000, 4, 3, 1);
        prog[4]  = lui_word(5, 20'h12345);
        prog[5]  = reg_op_word(7'h00, 3'b100, 6, 5, 4);
        prog[6]  = reg_op_word(7'h00, 3'b110, 7, 6, 3);
        prog[7]  = reg_op_word(7'h00, 3'b111, 8, 7, 5);
        prog[8]  = addi_word(9, 0, -1);
        prog[9]  = lui_word(10, 20'h80000);
        prog[10] = reg_op_word(7'h00, 3'b000, 11, 9, 10);
        prog[11] = addi_word(0, 1, 99);                    // x0 write is dropped
        prog[12] = reg_op_word(7'h00, 3'b000, 12, 0, 1);
        prog[13] = reg_op_word(7'h00, 3'b000, 13, 0, 0);
        prog[14] = branch_word(3'b000, 1, 2, 8);           // not taken
        prog[15] = addi_word(14, 0, 1);
        prog[16] = branch_word(3'b001, 1, 2, 12);          // taken to 19
        prog[17] = addi_word(15, 0, 66);
        prog[18] = addi_word(15, 0, 77);
        prog[19] = branch_word(3'b000, 12, 1, 12);         // taken to 22
        prog[20] = addi_word(16, 0, 55);
        prog[21] = jal_word(1, 40);                        // wrong path JAL in decode
        prog[22] = jal_word(17, 12);
        prog[23] = addi_word(18, 0, 11);
        prog[24] = addi_word(18, 0, 22);
        prog[25] = reg_op_word(7'h00, 3'b000, 19, 17, 1);
        prog[26] = branch_word(3'b001, 0, 0, 8);
        prog[27] = addi_word(20, 19, -3);
        prog[28] = jal_word(21, 8);
        prog[29] = addi_word(22, 0, 9);
        prog[30] = reg_op_word(7'h00, 3'b000, 23, 21, 20);
        prog[31] = reg_op_word(7'h00, 3'b001, 24, 1, 1);   // SLL, outside the subset
        prog[32] = reg_op_word(7'h00, 3'b000, 25, 23, 1);
        prog[33] = addi_word(26, 0, 3);
        prog[34] = addi_word(26, 26, -1);
        prog[35] = branch_word(3'b001, 26, 0, -4);         // loops twice
        prog[36] = reg_op_word(7'h00, 3'b000, 27, 26, 25);
    endtask

    // In-order ISA model that queues the expected commits
    task automatic build_expected();
        addr_t       pc;
        addr_t       next_pc;
        logic [31:0] w;
        bus64_t      a;
        bus64_t      b;
        bus64_t      res;
        logic        we;
        int          steps;
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
        pc = RESET_ADDR;
        steps = 0;
        while (pc >= RESET_ADDR && pc < RESET_ADDR + 4 * PROG_LEN && steps < 1000) begin
            w = word_at(pc);
            a = gold_regs[w[19:15]];
            b = gold_regs[w[24:20]];
            we = 1'b0;
            res = '0;
            next_pc = pc + 4;
            case (w[6:0])
                7'b0110011: begin
                    we = 1'b1;
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        default:         we = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    we = (w[14:12] == 3'b000);
                    res = a + {{52{w[31]}}, w[31:20]};
                end
                7'b0110111: begin
                    we = 1'b1;
                    res = {{32{w[31]}}, w[31:12], 12'h000};
                end
                7'b1100011: begin
                    if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
                        next_pc = pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    we = 1'b1;
                    res = pc + 4;
                    next_pc = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            if (w[11:7] == 5'd0) begin
                we = 1'b0;
            end
            if (we) begin
                gold_regs[w[11:7]] = res;
            end
            exp_pc.push_back(pc);
            exp_we.push_back(we);
            exp_rd.push_back(w[11:7]);
            exp_data.push_back(res);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_value(input string name, input bus64_t expected, input bus64_t actual);
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Capture the request that the next response belongs to
    always @(negedge clk_i) begin
        pend_valid = rstn_i && icache_req_valid_o;
        pend_addr  = icache_req_addr_o;
    end

    // Memory response for the previous request, sometimes withheld
    initial begin
        void'($urandom(13943));
        forever begin
            @(posedge clk_i);
            #5;
            icache_resp_valid_i = pend_valid && (!withhold_en || ($urandom % 3) != 0);
            icache_resp_instr_i = word_at(pend_addr);
        end
    end

    // Commit checker against the head of the golden queue
    always @(negedge clk_i) begin
        if (rstn_i && commit_valid_o && exp_pc.size() > 0) begin
            check_value("commit_pc_o", exp_pc[0], commit_pc_o);
            check_value("commit_we_o", exp_we[0], commit_we_o);
            if (exp_we[0]) begin
                check_value("commit_rd_o", exp_rd[0], commit_rd_o);
                check_value("commit_data_o", exp_data[0], commit_data_o);
            end
            void'(exp_pc.pop_front());
            void'(exp_we.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            checked++;
        end
    end

    task automatic run_phase(input logic withhold, input string label);
        int cycles;
        withhold_en = withhold;
        @(posedge clk_i);
        #5;
        rstn_i = 1'b0;
        build_expected();
        repeat (10) @(posedge clk_i);
        #5;
        rstn_i = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            check_value("commit_valid_o", 64'd0, commit_valid_o);
        end while (!icache_req_valid_o && cycles < 20);
        if (!icache_req_valid_o) begin
            $display("Timeout: no fetch request within 20 cycles after reset (%s)", label);
            timeouts++;
            return;
        end
        check_value("icache_req_addr_o", RESET_ADDR, icache_req_addr_o);
        cycles = 0;
        while (exp_pc.size() != 0 && cycles < 2000) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_pc.size() != 0) begin
            $display("Timeout: %0d expected commits never retired in %0d cycles (%s)",
                     exp_pc.size(), cycles, label);
            timeouts++;
        end
    endtask

    initial begin
        clk_i               = 1'b0;
        rstn_i              = 1'b0;
        reset_addr_i        = RESET_ADDR;
        icache_resp_valid_i = 1'b0;
        icache_resp_instr_i = NOP_INSTR;
        withhold_en         = 1'b0;
        pend_valid          = 1'b0;
        pend_addr           = '0;
        errors              = 0;
        timeouts            = 0;
        checked             = 0;
        foreach (gold_regs[i]) begin
            gold_regs[i] = '0;
        end
        load_program();
        run_phase(1'b0, "responses always valid");
        run_phase(1'b1, "responses randomly withheld");
        $display("Errors: %0d mismatches, %0d timeouts, %0d commits checked",
                 errors, timeouts, checked);
        if (errors == 0 && timeouts == 0 && checked > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/riscv_pkg.sv
rtl/drac_pkg.sv
rtl/stage_ctrl_if.sv
rtl/if_stage.sv
rtl/decoder.sv
rtl/rr_stage.sv
rtl/exe_stage.sv
rtl/control_unit.sv
rtl/datapath.sv
sim/tb_datapath.sv

// File: Bender.yml
package:
  name: drac_datapath

sources:
  - rtl/riscv_pkg.sv
  - rtl/drac_pkg.sv
  - rtl/stage_ctrl_if.sv
  - rtl/if_stage.sv
  - rtl/decoder.sv
  - rtl/rr_stage.sv
  - rtl/exe_stage.sv
  - rtl/control_unit.sv
  - rtl/datapath.sv
  - target: simulation
    files:
      - sim/tb_datapath.sv
